/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = fetchTb
FILELIST = all.f
OBJDIR   = obj_dir
LOG      = sim.log
PASS     = all tests passed

.PHONY: lint sim clean

lint:
	$(TOOL) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

sim:
	$(TOOL) $(FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS)" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

/* all.f */
+incdir+test
hw/fetchPkg.sv
hw/predictLookupIf.sv
hw/branchPredictor.sv
hw/returnStack.sv
hw/creditCounter.sv
hw/fetchControl.sv
hw/fetchStage1.sv
test/fetchTb.sv

/* hw/branchPredictor.sv */
// Branch target buffer plus a table of two-bit direction counters.
// Looks up all four slots of the bundle at pc_i in the same cycle.
// One training port, fed in program order, writes at the clock edge.
// Both tables use the address without its 3 low bits, modulo btbEntries.

`timescale 1ns/1ns

module branchPredictor #(
	parameter int btbEntries = 64
) (
	input  logic              clk,
	input  logic              reset,
	input  fetchPkg::pcT      pc_i,
	input  logic              updateEn_i,
	input  fetchPkg::pcT      updatePc_i,
	input  fetchPkg::pcT      updateTarget_i,
	input  fetchPkg::brTypeT  updateType_i,
	input  logic              updateTaken_i,
	predictLookupIf.producer  lookup
);

	localparam int offW = $clog2(fetchPkg::instBytes);   // Dropped low bits
	localparam int idxW = $clog2(btbEntries);
	localparam int tagW = $bits(fetchPkg::pcT) - offW - idxW;

	typedef logic [idxW-1:0] btbIdxT;
	typedef logic [tagW-1:0] btbTagT;
	typedef logic [1:0]      ctrT;       // Two-bit saturating counter

	logic                validArr  [btbEntries];
	btbTagT              tagArr    [btbEntries];
	fetchPkg::brTypeT    typeArr   [btbEntries];
	fetchPkg::pcT        targetArr [btbEntries];
	ctrT                 ctrArr    [btbEntries];

	btbIdxT  updIdx;
	logic    btbWrite;    // Buffer write this edge
	logic    ctrWrite;    // Counter change this edge

	function automatic btbIdxT idxOf(fetchPkg::pcT addr);
		return addr[offW +: idxW];
	endfunction

	function automatic btbTagT tagOf(fetchPkg::pcT addr);
		return addr[$bits(fetchPkg::pcT)-1 -: tagW];
	endfunction

	// ********************
	// Four-slot lookup
	// ********************

	always_comb
	begin
		fetchPkg::pcT slotPc;
		btbIdxT       idx;
		for (int s = 0; s < fetchPkg::slotCount; s++)
		begin
			slotPc = pc_i + fetchPkg::pcT'(s * fetchPkg::instBytes);
			idx    = idxOf(slotPc);
			lookup.hit[s]    = validArr[idx] && (tagArr[idx] == tagOf(slotPc));
			lookup.brType[s] = typeArr[idx];
			lookup.target[s] = targetArr[idx];
			// Unconditional types are always taken, else counter MSB
			lookup.taken[s]  = (typeArr[idx] != fetchPkg::brCond) || ctrArr[idx][1];
		end
	end

	// ********************
	// Training
	// ********************

	assign updIdx = idxOf(updatePc_i);
	// Not-taken conditionals leave the buffer alone
	assign btbWrite = updateEn_i && ((updateType_i != fetchPkg::brCond) || updateTaken_i);
	assign ctrWrite = updateEn_i && (updateType_i == fetchPkg::brCond);

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < btbEntries; i++)
			begin
				validArr[i] <= 1'b0;
				ctrArr[i]   <= '0;    // Strongly not taken
			end
		end
		else
		begin
			if (btbWrite)
				validArr[updIdx] <= 1'b1;
			if (ctrWrite)
			begin
				if (updateTaken_i && (ctrArr[updIdx] != 2'd3))
					ctrArr[updIdx] <= ctrArr[updIdx] + 2'd1;
				else if (!updateTaken_i && (ctrArr[updIdx] != 2'd0))
					ctrArr[updIdx] <= ctrArr[updIdx] - 2'd1;
			end
		end
	end

	// Entry payload, qualified by validArr
	always_ff @(posedge clk)
	begin
		if (btbWrite)
		begin
			tagArr[updIdx]    <= tagOf(updatePc_i);
			typeArr[updIdx]   <= updateType_i;
			targetArr[updIdx] <= updateTarget_i;
		end
	end

	// Training stream from the branch queue must carry a defined type
	assert property (@(posedge clk) disable iff (reset)
		updateEn_i |-> !$isunknown(updateType_i))
		else $error("branch update with unknown type");

endmodule

/* hw/creditCounter.sv */
// Decode-stage credits held by the fetch stage.
// Starts full after reset. A spend takes one, a return gives one back,
// both together leave the count alone.

`timescale 1ns/1ns

module creditCounter #(
	parameter int creditMax = 4
) (
	input  logic clk,
	input  logic reset,
	input  logic spend_i,       // Bundle sent this cycle
	input  logic return_i,      // Decode consumed a bundle
	output logic available_o
);

	localparam int cntW = $clog2(creditMax + 1);

	typedef logic [cntW-1:0] creditT;

	creditT count;

	always_ff @(posedge clk)
	begin
		if (reset)
			count <= creditT'(creditMax);
		else if (spend_i && !return_i)
			count <= count - creditT'(1);
		else if (return_i && !spend_i)
			count <= count + creditT'(1);
	end

	assign available_o = (count != '0);

	// Controller must only send while a credit is left
	assert property (@(posedge clk) disable iff (reset) spend_i |-> (count != '0))
		else $error("credit underflow");
	// Decode cannot give back more than it was given
	assert property (@(posedge clk) disable iff (reset)
		return_i |-> (count != creditT'(creditMax)))
		else $error("credit overflow");

endmodule

/* hw/fetchControl.sv */
// Fetch controller with the state machine and the program counter.
// Next address priority is execute recovery, then decode recovery, then the
// first predicted-taken slot, then PC + 32. Drives the return stack for
// predicted calls/returns and for decode recoveries.

`timescale 1ns/1ns

module fetchControl (
	input  logic              clk,
	input  logic              reset,
	input  logic              creditAvail_i,
	input  logic              recoverEx_i,
	input  fetchPkg::pcT      recoverExPc_i,
	input  logic              recoverId_i,
	input  fetchPkg::pcT      recoverIdPc_i,
	input  logic              recoverIdRet_i,
	input  logic              recoverIdCall_i,
	input  fetchPkg::pcT      recoverIdCallPc_i,
	input  fetchPkg::pcT      rasTop_i,
	predictLookupIf.consumer  lookup,
	output fetchPkg::pcT      pc_o,
	output fetchPkg::pcT      nextPc_o,
	output fetchPkg::slotIdxT takenSlot_o,
	output logic              predTaken_o,
	output logic              valid_o,
	output logic              push_o,
	output fetchPkg::pcT      pushAddr_o,
	output logic              pop_o
);

	fetchPkg::fetchStateT state;
	fetchPkg::fetchStateT nextState;
	fetchPkg::pcT         pcReg;
	fetchPkg::pcT         predPc;       // Predicted or sequential next address
	fetchPkg::pcT         slotPc;       // Address of the first taken slot
	fetchPkg::brTypeT     takenType;
	fetchPkg::slotIdxT    firstSlot;
	logic                 anyTaken;
	logic                 recoverAny;

	assign recoverAny = recoverEx_i || recoverId_i;
	assign valid_o    = (state == fetchPkg::RUN) && creditAvail_i;

	// ********************
	// Prediction select
	// ********************

	// Walk down so the lowest taken slot wins
	always_comb
	begin
		anyTaken  = 1'b0;
		firstSlot = '0;
		for (int s = fetchPkg::slotCount - 1; s >= 0; s--)
		begin
			if (lookup.hit[s] && lookup.taken[s])
			begin
				anyTaken  = 1'b1;
				firstSlot = fetchPkg::slotIdxT'(s);
			end
		end
	end

	assign takenType = lookup.brType[firstSlot];
	assign slotPc    = pcReg + fetchPkg::pcT'(int'(firstSlot) * fetchPkg::instBytes);

	always_comb
	begin
		if (!anyTaken)
			predPc = pcReg + fetchPkg::pcT'(fetchPkg::fetchStep);
		else if (takenType == fetchPkg::brReturn)
			predPc = rasTop_i;      // Returns ignore the stored target
		else
			predPc = lookup.target[firstSlot];
	end

	// Recoveries override prediction with execute first
	always_comb
	begin
		if (recoverEx_i)
			nextPc_o = recoverExPc_i;
		else if (recoverId_i)
			nextPc_o = recoverIdRet_i ? rasTop_i : recoverIdPc_i;
		else
			nextPc_o = predPc;
	end

	// ********************
	// Return stack control
	// ********************

	always_comb
	begin
		push_o     = 1'b0;
		pop_o      = 1'b0;
		pushAddr_o = slotPc + fetchPkg::pcT'(fetchPkg::instBytes);  // Call slot + 8
		if (recoverEx_i)
		begin
			// No stack repair on execute redirect
		end
		else if (recoverId_i)
		begin
			push_o     = recoverIdCall_i;
			pushAddr_o = recoverIdCallPc_i;
			pop_o      = recoverIdRet_i;
		end
		else if (valid_o && anyTaken)
		begin
			push_o = (takenType == fetchPkg::brCall);
			pop_o  = (takenType == fetchPkg::brReturn);
		end
	end

	// ********************
	// State and PC
	// ********************

	always_comb
	begin
		nextState = state;
		if (recoverAny)
			nextState = fetchPkg::RECOVER;
		else
		begin
			unique case (state)
				fetchPkg::RUN:
					if (!creditAvail_i)
						nextState = fetchPkg::NOCREDIT;
				fetchPkg::NOCREDIT, fetchPkg::RECOVER:
					nextState = creditAvail_i ? fetchPkg::RUN : fetchPkg::NOCREDIT;
				default:
					nextState = fetchPkg::RUN;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= fetchPkg::RUN;
			pcReg <= '0;
		end
		else
		begin
			state <= nextState;
			if (recoverAny || valid_o)
				pcReg <= nextPc_o;     // Hold while stalled on credits
		end
	end

	assign pc_o        = pcReg;
	assign takenSlot_o = firstSlot;
	assign predTaken_o = anyTaken;

endmodule

/* hw/fetchPkg.sv */
// Shared definitions for the first fetch stage.
// Design files refer to them as fetchPkg::name.
// Covers address and slot widths, branch type encodings and controller states.

package fetchPkg;

	// ********************
	// Addresses and slots
	// ********************

	typedef logic [31:0] pcT;          // Fetch or target address

	localparam int slotCount = 4;      // Slots per bundle
	localparam int instBytes = 8;      // Bytes per slot
	localparam int fetchStep = slotCount * instBytes;    // Sequential step, 32 bytes

	typedef logic [$clog2(slotCount)-1:0] slotIdxT;     // Slot number inside a bundle

	// ********************
	// Branch types
	// ********************

	// Jump is 2 and needs no special handling, so it has no constant here
	typedef logic [1:0] brTypeT;

	localparam brTypeT brReturn = 2'd0;    // Target comes from the return stack
	localparam brTypeT brCall   = 2'd1;    // Pushes its return address
	localparam brTypeT brCond   = 2'd3;    // Direction from the counter table

	// ********************
	// Controller states
	// ********************

	typedef enum logic [1:0]
	{
		RUN,        // Bundle goes out when a credit is left
		NOCREDIT,   // Decode full, PC holds
		RECOVER     // One dead cycle after a redirect
	} fetchStateT;

endpackage

/* hw/fetchStage1.sv */
// Top of the first fetch stage.
// Ties the predictor, return stack, credit counter and controller together
// and sets the table sizes. Outputs one bundle address per credit.

`timescale 1ns/1ns

module fetchStage1 #(
	parameter int btbEntries = 64,
	parameter int rasDepth   = 8,
	parameter int creditMax  = 4
) (
	input  logic              clk,
	input  logic              reset,
	input  logic              recoverEx_i,
	input  fetchPkg::pcT      recoverExPc_i,
	input  logic              recoverId_i,
	input  fetchPkg::pcT      recoverIdPc_i,
	input  logic              recoverIdRet_i,
	input  logic              recoverIdCall_i,
	input  fetchPkg::pcT      recoverIdCallPc_i,
	input  logic              updateEn_i,
	input  fetchPkg::pcT      updatePc_i,
	input  fetchPkg::pcT      updateTarget_i,
	input  fetchPkg::brTypeT  updateType_i,
	input  logic              updateTaken_i,
	input  logic              creditReturn_i,
	output logic              bundleValid_o,
	output fetchPkg::pcT      bundlePc_o,
	output fetchPkg::pcT      nextPc_o,
	output fetchPkg::slotIdxT takenSlot_o,
	output logic              predTaken_o
);

	fetchPkg::pcT pc;
	fetchPkg::pcT rasTop;
	fetchPkg::pcT pushAddr;
	logic         push;
	logic         pop;
	logic         creditAvail;

	predictLookupIf lookupBus ();    // Predictor to controller

	branchPredictor #(.btbEntries(btbEntries)) predictor (
		.clk(clk), .reset(reset), .pc_i(pc),
		.updateEn_i(updateEn_i), .updatePc_i(updatePc_i),
		.updateTarget_i(updateTarget_i), .updateType_i(updateType_i),
		.updateTaken_i(updateTaken_i), .lookup(lookupBus)
	);

	returnStack #(.rasDepth(rasDepth)) ras (
		.clk(clk), .reset(reset), .push_i(push), .pushAddr_i(pushAddr),
		.pop_i(pop), .top_o(rasTop)
	);

	// Each valid bundle spends one decode slot
	creditCounter #(.creditMax(creditMax)) credits (
		.clk(clk), .reset(reset), .spend_i(bundleValid_o),
		.return_i(creditReturn_i), .available_o(creditAvail)
	);

	fetchControl control (
		.clk(clk), .reset(reset), .creditAvail_i(creditAvail),
		.recoverEx_i(recoverEx_i), .recoverExPc_i(recoverExPc_i),
		.recoverId_i(recoverId_i), .recoverIdPc_i(recoverIdPc_i),
		.recoverIdRet_i(recoverIdRet_i), .recoverIdCall_i(recoverIdCall_i),
		.recoverIdCallPc_i(recoverIdCallPc_i), .rasTop_i(rasTop),
		.lookup(lookupBus), .pc_o(pc), .nextPc_o(nextPc_o),
		.takenSlot_o(takenSlot_o), .predTaken_o(predTaken_o),
		.valid_o(bundleValid_o), .push_o(push), .pushAddr_o(pushAddr), .pop_o(pop)
	);

	assign bundlePc_o = pc;

endmodule

/* hw/predictLookupIf.sv */
// Bundle-wide lookup results from the predictor to the fetch controller.
// One entry per slot. The predictor drives it through the producer modport
// and the controller reads it through the consumer modport.

`timescale 1ns/1ns

interface predictLookupIf;

	logic [fetchPkg::slotCount-1:0]                  hit;     // Tag match on a valid entry
	fetchPkg::brTypeT [fetchPkg::slotCount-1:0]      brType;  // Stored branch type
	fetchPkg::pcT [fetchPkg::slotCount-1:0]          target;  // Stored target
	logic [fetchPkg::slotCount-1:0]                  taken;   // Predicted direction

	// Predictor side
	modport producer
	(
		output hit, brType, target, taken
	);

	// Controller side
	modport consumer
	(
		input hit, brType, target, taken
	);

endinterface

/* hw/returnStack.sv */
// Circular return address stack for call/return prediction.
// Overflow wraps onto the oldest entry. A pop when empty keeps the pointer
// and shows the same top again. Push with pop in one cycle swaps the top.

`timescale 1ns/1ns

module returnStack #(
	parameter int rasDepth = 8
) (
	input  logic          clk,
	input  logic          reset,
	input  logic          push_i,
	input  fetchPkg::pcT  pushAddr_i,
	input  logic          pop_i,
	output fetchPkg::pcT  top_o
);

	localparam int ptrW  = (rasDepth > 1) ? $clog2(rasDepth) : 1;
	localparam int fillW = $clog2(rasDepth + 1);

	typedef logic [ptrW-1:0]  rasPtrT;
	typedef logic [fillW-1:0] rasFillT;

	fetchPkg::pcT  stackArr [rasDepth];
	rasPtrT        topPtr;      // Slot of the current top
	rasFillT       fill;        // Live entries, 0 means empty
	rasPtrT        nextPtr;
	rasPtrT        prevPtr;

	// Wrap both ways, depth need not be a power of two
	assign nextPtr = (topPtr == rasPtrT'(rasDepth - 1)) ? '0 : topPtr + rasPtrT'(1);
	assign prevPtr = (topPtr == '0) ? rasPtrT'(rasDepth - 1) : topPtr - rasPtrT'(1);

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			topPtr <= '0;
			fill   <= '0;
			for (int i = 0; i < rasDepth; i++)
				stackArr[i] <= '0;
		end
		else if (push_i && pop_i)
			stackArr[topPtr] <= pushAddr_i;    // Replace top, depth unchanged
		else if (push_i)
		begin
			topPtr           <= nextPtr;
			stackArr[nextPtr] <= pushAddr_i;
			if (fill != rasFillT'(rasDepth))
				fill <= fill + rasFillT'(1);   // Full stays full, oldest lost
		end
		else if (pop_i && (fill != '0))
		begin
			topPtr <= prevPtr;
			fill   <= fill - rasFillT'(1);
		end
	end

	assign top_o = stackArr[topPtr];

endmodule

/* test/fetchModel.svh */
// Reference model of the fetch stage, included by the testbench.
// Keeps its own predictor tables, return stack, credit count, state and PC.
// predictCycle gives the expected outputs of a cycle, advanceModel applies the edge.

`ifndef FETCH_MODEL_SVH
`define FETCH_MODEL_SVH

// ********************
// Model state
// ********************

logic        mValid  [btbEntries];
logic [31:0] mTag    [btbEntries];
logic [1:0]  mType   [btbEntries];
logic [31:0] mTarget [btbEntries];
int          mCtr    [btbEntries];    // Two-bit counter kept as 0..3
logic [31:0] mStack  [rasDepth];
int          mTop;                    // Top slot of the stack
int          mFill;                   // Live stack entries
int          mCredits;
int          mState;                  // 0 RUN, 1 NOCREDIT, 2 RECOVER
logic [31:0] mPc;

// Expected outputs of the current cycle
logic        eValid;
logic        eTaken;
logic        ePush;
logic        ePop;
logic [31:0] eNextPc;
logic [31:0] ePushAddr;
int          eSlot;

function automatic int slotIndex(logic [31:0] a);
	return int'((a >> 3) % btbEntries);    // Drop byte offset, wrap on table size
endfunction

function automatic logic [31:0] slotTag(logic [31:0] a);
	return (a >> 3) / btbEntries;          // Bits above the index
endfunction

task automatic resetModel();
	for (int k = 0; k < btbEntries; k++)
	begin
		mValid[k] = 1'b0;
		mCtr[k]   = 0;
	end
	for (int k = 0; k < rasDepth; k++)
		mStack[k] = '0;
	mTop     = 0;
	mFill    = 0;
	mCredits = creditMax;
	mState   = 0;
	mPc      = '0;
endtask

// Expected outputs from model state and the inputs driven this cycle
task automatic predictCycle();
	logic [31:0] slotPc;
	logic [31:0] predPc;
	logic [1:0]  typ;
	int          i;
	eTaken = 1'b0;
	eSlot  = 0;
	for (int s = 0; s < slotCount; s++)
	begin
		slotPc = mPc + 32'(s * instBytes);
		i      = slotIndex(slotPc);
		if (!eTaken && mValid[i] && (mTag[i] == slotTag(slotPc))
			&& ((mType[i] != 2'd3) || (mCtr[i] >= 2)))
		begin
			eTaken = 1'b1;    // Lowest taken slot wins
			eSlot  = s;
		end
	end
	i      = slotIndex(mPc + 32'(eSlot * instBytes));
	typ    = mType[i];
	predPc = !eTaken ? mPc + 32'(slotCount * instBytes)
		: (typ == 2'd0) ? mStack[mTop] : mTarget[i];
	eValid = (mState == 0) && (mCredits > 0);
	if (recoverEx)
		eNextPc = recoverExPc;
	else if (recoverId)
		eNextPc = recoverIdRet ? mStack[mTop] : recoverIdPc;
	else
		eNextPc = predPc;
	ePush     = 1'b0;
	ePop      = 1'b0;
	ePushAddr = mPc + 32'((eSlot + 1) * instBytes);    // Address after the call
	if (!recoverEx && recoverId)
	begin
		ePush     = recoverIdCall;
		ePop      = recoverIdRet;
		ePushAddr = recoverIdCallPc;
	end
	else if (!recoverEx && eValid && eTaken)
	begin
		ePush = (typ == 2'd1);
		ePop  = (typ == 2'd0);
	end
endtask

// Clock edge: training, stack, credits, state, PC
task automatic advanceModel();
	int i;
	if (updateEn)
	begin
		i = slotIndex(updatePc);
		if ((updateType != 2'd3) || updateTaken)
		begin
			mValid[i]  = 1'b1;
			mTag[i]    = slotTag(updatePc);
			mType[i]   = updateType;
			mTarget[i] = updateTarget;
		end
		if (updateType == 2'd3)
		begin
			if (updateTaken && (mCtr[i] < 3))
				mCtr[i] = mCtr[i] + 1;
			else if (!updateTaken && (mCtr[i] > 0))
				mCtr[i] = mCtr[i] - 1;
		end
	end
	if (ePush && ePop)
		mStack[mTop] = ePushAddr;    // Swap top
	else if (ePush)
	begin
		mTop         = (mTop + 1) % rasDepth;
		mStack[mTop] = ePushAddr;
		if (mFill < rasDepth)
			mFill = mFill + 1;
	end
	else if (ePop && (mFill > 0))
	begin
		mTop  = (mTop + rasDepth - 1) % rasDepth;
		mFill = mFill - 1;
	end
	if (recoverEx || recoverId || eValid)
		mPc = eNextPc;
	// State looks at the count before this edge
	mState   = (recoverEx || recoverId) ? 2 : ((mCredits > 0) ? 0 : 1);
	mCredits = mCredits + (creditReturn ? 1 : 0) - (eValid ? 1 : 0);
endtask

`endif

/* test/fetchTb.sv */
// Testbench for the first fetch stage.
// Random training, credit returns and recoveries from a fixed seed, driven on
// the falling edge. Every cycle the DUT outputs are compared with the model.

`timescale 1ns/1ns

module fetchTb;

	localparam int btbEntries  = 64;
	localparam int rasDepth    = 8;
	localparam int creditMax   = 4;
	localparam int slotCount   = 4;
	localparam int instBytes   = 8;
	localparam int clkPeriod   = 10;
	localparam int resetCycles = 5;
	localparam int testCycles  = 2000;
	localparam int quietCycles = 100;     // Sequential phase without training

	logic               clk;
	logic               reset;
	logic               recoverEx;
	logic [31:0]        recoverExPc;
	logic               recoverId;
	logic [31:0]        recoverIdPc;
	logic               recoverIdRet;
	logic               recoverIdCall;
	logic [31:0]        recoverIdCallPc;
	logic               updateEn;
	logic [31:0]        updatePc;
	logic [31:0]        updateTarget;
	logic [1:0]         updateType;
	logic               updateTaken;
	logic               creditReturn;
	logic               bundleValid;
	logic [31:0]        bundlePc;
	logic [31:0]        nextPc;
	fetchPkg::slotIdxT  takenSlot;
	logic               predTaken;

	`include "fetchModel.svh"

	fetchStage1 #(
		.btbEntries(btbEntries),
		.rasDepth(rasDepth),
		.creditMax(creditMax)
	) u_dut (
		.clk(clk), .reset(reset),
		.recoverEx_i(recoverEx), .recoverExPc_i(recoverExPc),
		.recoverId_i(recoverId), .recoverIdPc_i(recoverIdPc),
		.recoverIdRet_i(recoverIdRet), .recoverIdCall_i(recoverIdCall),
		.recoverIdCallPc_i(recoverIdCallPc),
		.updateEn_i(updateEn), .updatePc_i(updatePc), .updateTarget_i(updateTarget),
		.updateType_i(updateType), .updateTaken_i(updateTaken),
		.creditReturn_i(creditReturn),
		.bundleValid_o(bundleValid), .bundlePc_o(bundlePc), .nextPc_o(nextPc),
		.takenSlot_o(takenSlot), .predTaken_o(predTaken)
	);

	always #(clkPeriod / 2) clk = ~clk;

	// ********************
	// Helpers
	// ********************

	task automatic check(string name, logic [31:0] got, logic [31:0] exp);
		if (got !== exp)
		begin
			$display("[FAIL] %s: got %h, expected %h", name, got, exp);
			$display("tests failed");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	// Slot-aligned address in a 1 KB window with two tags per index
	function automatic logic [31:0] pickAddr();
		return ($urandom % 128) * 8;
	endfunction

	task automatic driveCycle(bit quiet);
		int r;
		creditReturn    = (mCredits < creditMax) && ($urandom % 2 == 0);  // Only spent credits
		updateEn        = !quiet && ($urandom % 3 == 0);
		updatePc        = pickAddr();
		updateTarget    = pickAddr();
		updateType      = 2'($urandom % 4);
		updateTaken     = ($urandom % 4 != 0);
		r               = quiet ? 100 : int'($urandom % 100);
		recoverEx       = (r < 3);
		recoverId       = (r >= 2) && (r < 4);     // r == 2 hits both at once
		recoverExPc     = pickAddr();
		recoverIdPc     = pickAddr();
		recoverIdCallPc = pickAddr();
		recoverIdRet    = recoverId && ($urandom % 3 == 0);
		recoverIdCall   = recoverId && !recoverIdRet && ($urandom % 3 == 0);
	endtask

	task automatic compareOutputs();
		check("bundleValid_o", 32'(bundleValid), 32'(eValid));
		check("bundlePc_o", bundlePc, mPc);
		check("nextPc_o", nextPc, eNextPc);
		check("predTaken_o", 32'(predTaken), 32'(eTaken));
		if (eTaken)
			check("takenSlot_o", 32'(takenSlot), 32'(eSlot));
	endtask

	// ********************
	// Main sequence
	// ********************

	initial
	begin
		logic [31:0] seqPc;    // Expected address of the next sequential bundle
		void'($urandom(32'h6252_e3db));
		clk             = 1'b0;
		reset           = 1'b1;
		recoverEx       = 1'b0;
		recoverExPc     = '0;
		recoverId       = 1'b0;
		recoverIdPc     = '0;
		recoverIdRet    = 1'b0;
		recoverIdCall   = 1'b0;
		recoverIdCallPc = '0;
		updateEn        = 1'b0;
		updatePc        = '0;
		updateTarget    = '0;
		updateType      = '0;
		updateTaken     = 1'b0;
		creditReturn    = 1'b0;
		seqPc           = '0;
		resetModel();
		repeat (resetCycles) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		for (int c = 0; c < testCycles; c++)
		begin
			driveCycle(c < quietCycles);
			#2;                          // Let the lookup settle
			predictCycle();
			compareOutputs();
			if (bundleValid && (c < quietCycles))
			begin
				// Untrained tables give plain 32-byte steps from address 0
				check("bundlePc_o", bundlePc, seqPc);
				seqPc = seqPc + 32'(slotCount * instBytes);
			end
			@(posedge clk);
			advanceModel();
			@(negedge clk);
		end
		$display("all tests passed");
		$finish;
	end

	// Watchdog over the whole run
	initial
	begin
		#((resetCycles + testCycles + 50) * clkPeriod);
		$display("Watchdog expired before the test loop finished");
		$display("tests failed");
		$fatal(1, "timeout");
	end

endmodule
